/* tank_game.f */
logic/tank_pkg.sv
logic/tank_regs_pkg.sv
logic/tick_gen.sv
logic/player_tank.sv
logic/shell_unit.sv
logic/tank_apb_regs.sv
logic/tank_game.sv
test/tank_game_asserts.sv
test/tank_game_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tank_game_tb
FILELIST = tank_game.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

# the run passes only when the testbench prints its pass line
test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* test/tank_game_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module tank_game_tb
	import tank_pkg::*;
	import tank_regs_pkg::*;
();

	localparam int CLK_HALF     = 50;
	localparam int XFER_TIMEOUT = 16;
	localparam int POLL_TIMEOUT = 40;

	// tank and shell as the host sees them
	typedef struct packed {
		coord_t x;
		coord_t y;
		dir_t   dir;
		logic   alive;
		logic   sh_act;
		coord_t sh_x;
		coord_t sh_y;
		dir_t   sh_dir;
	} game_t;

	logic              clk;
	logic              rst_n;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	wire  [APB_DW-1:0] prdata;
	wire               pready;
	wire               pslverr;

	// reference model state
	game_t              m;
	logic               m_en;
	logic [4:0]         m_btn;
	logic [N_ENEMY-1:0] m_ev;
	coord_t             m_ex [N_ENEMY];
	coord_t             m_ey [N_ENEMY];

	int          errors;
	int          checks;
	int          hold;
	int          polls;
	logic [31:0] seed;
	logic [31:0] rd;
	logic [31:0] saved;
	logic [4:0]  sweep [4];

	tank_game UUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic enemy_at(input coord_t x, input coord_t y);
		logic h;
		h = 1'b0;
		for (int i = 0; i < N_ENEMY; i++)
			if (m_ev[i] && (m_ex[i] == x) && (m_ey[i] == y))
				h = 1'b1;
		return h;
	endfunction

	function automatic game_t next_state(input game_t s, input logic en, input logic [4:0] btn);
		game_t n;
		logic  shot;
		n    = s;
		shot = 1'b0;
		// shell in flight moves one cell, or leaves the field
		if (s.sh_act)
		begin
			case (s.sh_dir)
				DIR_UP:
					if (s.sh_y < Y_MAX)
						n.sh_y = s.sh_y + 5'd1;
					else
						n.sh_act = 1'b0;
				DIR_DOWN:
					if (s.sh_y > 5'd0)
						n.sh_y = s.sh_y - 5'd1;
					else
						n.sh_act = 1'b0;
				DIR_LEFT:
					if (s.sh_x > 5'd0)
						n.sh_x = s.sh_x - 5'd1;
					else
						n.sh_act = 1'b0;
				default:
					if (s.sh_x < X_MAX)
						n.sh_x = s.sh_x + 5'd1;
					else
						n.sh_act = 1'b0;
			endcase
		end
		// first pressed button wins, the tank stops at the edges
		if (en && s.alive)
		begin
			if (btn[BTN_UP])
			begin
				n.dir = DIR_UP;
				if (s.y < Y_MAX)
					n.y = s.y + 5'd1;
			end
			else if (btn[BTN_DOWN])
			begin
				n.dir = DIR_DOWN;
				if (s.y > 5'd0)
					n.y = s.y - 5'd1;
			end
			else if (btn[BTN_LEFT])
			begin
				n.dir = DIR_LEFT;
				if (s.x > 5'd0)
					n.x = s.x - 5'd1;
			end
			else if (btn[BTN_RIGHT])
			begin
				n.dir = DIR_RIGHT;
				if (s.x < X_MAX)
					n.x = s.x + 5'd1;
			end
			shot = btn[BTN_FIRE] && !s.sh_act;
		end
		if (enemy_at(n.x, n.y))
			n.alive = 1'b0;
		// new shell starts from the tank cell and heading after the move
		if (shot)
		begin
			n.sh_act = 1'b1;
			n.sh_x   = n.x;
			n.sh_y   = n.y;
			n.sh_dir = n.dir;
		end
		return n;
	endfunction

	function automatic logic [31:0] status_word(input game_t s);
		logic [31:0] w;
		w = '0;
		w[FLD_X_LSB +: $bits(coord_t)]    = s.x;
		w[FLD_Y_LSB +: $bits(coord_t)]    = s.y;
		w[STATUS_DIR_LSB +: $bits(dir_t)] = s.dir;
		w[STATUS_ALIVE]                   = s.alive;
		w[STATUS_SHELL]                   = s.sh_act;
		return w;
	endfunction

	function automatic game_t spawn_state(input game_t s);
		game_t n;
		n        = s;
		n.x      = SPAWN_X;
		n.y      = SPAWN_Y;
		n.dir    = DIR_UP;
		n.alive  = 1'b1;
		n.sh_act = 1'b0;
		return n;
	endfunction

	// ------------------------------
	// compare and APB tasks
	// ------------------------------
	task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
			errors++;
		end
	endtask

	task automatic apb_transfer(input logic wr, input logic [APB_AW-1:0] addr,
		input logic [APB_DW-1:0] wdata, input logic exp_err, output logic [APB_DW-1:0] rdata);
		int   waited;
		logic err;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		waited  = 0;
		// access phase ends on the first rising edge with pready
		@(posedge clk);
		while (!pready && (waited < XFER_TIMEOUT))
		begin
			@(posedge clk);
			waited++;
		end
		rdata = prdata;
		err   = pslverr;
		if (!pready)
		begin
			$display("ERROR: APB transfer to 0x%h never completed", addr);
			errors++;
		end
		else
			compare($sformatf("pslverr at 0x%h", addr), 32'(exp_err), 32'(err));
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
		input logic exp_err);
		logic [APB_DW-1:0] unused;
		apb_transfer(1'b1, addr, data, exp_err, unused);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
		input logic exp_err);
		apb_transfer(1'b0, addr, '0, exp_err, data);
	endtask

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	// ------------------------------
	// game level helpers
	// ------------------------------
	task automatic check_state(input string name);
		logic [31:0] data;
		logic [31:0] exp;
		apb_read(ADDR_STATUS, data, 1'b0);
		compare({name, " status"}, status_word(m), data);
		// shell cell only means something while it flies
		if (m.sh_act)
		begin
			apb_read(ADDR_SHELL, data, 1'b0);
			exp = '0;
			exp[FLD_X_LSB +: $bits(coord_t)] = m.sh_x;
			exp[FLD_Y_LSB +: $bits(coord_t)] = m.sh_y;
			compare({name, " shell"}, exp, data);
		end
	endtask

	task automatic write_ctrl(input logic respawn, input logic step);
		logic [31:0] ctrl;
		ctrl               = '0;
		ctrl[CTRL_ENABLE]  = m_en;
		ctrl[CTRL_RESPAWN] = respawn;
		ctrl[CTRL_STEP]    = step;
		apb_write(ADDR_CTRL, ctrl, 1'b0);
	endtask

	task automatic set_buttons(input logic [4:0] b);
		m_btn = b;
		apb_write(ADDR_BTN, {27'b0, b}, 1'b0);
	endtask

	task automatic game_step(input string name);
		write_ctrl(1'b0, 1'b1);
		idle(4);
		m = next_state(m, m_en, m_btn);
		check_state(name);
	endtask

	task automatic place_enemy(input int slot, input coord_t x, input coord_t y, input logic v);
		logic [31:0] data;
		data = '0;
		data[FLD_X_LSB +: $bits(coord_t)] = x;
		data[FLD_Y_LSB +: $bits(coord_t)] = y;
		data[ENEMY_VALID]                 = v;
		apb_write(APB_AW'(ADDR_ENEMY0 + slot * ENEMY_STRIDE), data, 1'b0);
		m_ex[slot] = x;
		m_ey[slot] = y;
		m_ev[slot] = v;
		idle(4);
		if (enemy_at(m.x, m.y))
			m.alive = 1'b0;
	endtask

	task automatic respawn_tank(input string name);
		logic [31:0] data;
		write_ctrl(1'b1, 1'b0);
		idle(4);
		m = spawn_state(m);
		check_state(name);
		// spawn cell heading up and alive, no shell
		apb_read(ADDR_STATUS, data, 1'b0);
		compare({name, " spawn"}, 32'h0010_0707, data);
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		errors  = 0;
		checks  = 0;
		seed    = 32'h72ad;
		m_en    = 1'b0;
		m_btn   = '0;
		m_ev    = '0;
		for (int i = 0; i < N_ENEMY; i++)
		begin
			m_ex[i] = '0;
			m_ey[i] = '0;
		end
		m        = '0;
		m        = spawn_state(m);
		sweep[0] = 5'b00001;
		sweep[1] = 5'b01000;
		sweep[2] = 5'b00010;
		sweep[3] = 5'b00100;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		idle(2);

		// reset values and bus errors
		apb_read(ADDR_STATUS, rd, 1'b0);
		compare("reset status", 32'h0010_0707, rd);
		apb_write(ADDR_STATUS, 32'h0000_0101, 1'b1);
		apb_read(8'h40, rd, 1'b1);
		check_state("after bad access");

		// random walk, each pattern held for a few steps
		m_en = 1'b1;
		write_ctrl(1'b0, 1'b0);
		hold = 0;
		for (int n = 0; n < 200; n++)
		begin
			if (hold == 0)
			begin
				seed = lcg_next(seed);
				set_buttons({1'b0, seed[19:16]});
				hold = 1 + int'(seed[27:24]);
			end
			hold--;
			game_step("random move");
		end
		// drive into the top, right, bottom and left edges
		for (int d = 0; d < 4; d++)
		begin
			set_buttons(sweep[d]);
			repeat (Y_MAX + 2) game_step("edge sweep");
		end
		// bottom left corner, heading left, alive
		apb_read(ADDR_STATUS, rd, 1'b0);
		compare("corner reached", 32'h0012_0000, rd);

		// disabled game ignores steps
		apb_read(ADDR_STATUS, saved, 1'b0);
		m_en = 1'b0;
		set_buttons(5'b01000);
		repeat (5) game_step("disabled");
		apb_read(ADDR_STATUS, rd, 1'b0);
		compare("disabled no move", saved, rd);
		m_en = 1'b1;

		// fire upward, keep fire held while the shell flies
		set_buttons(5'b10001);
		game_step("launch");
		set_buttons(5'b10000);
		repeat (22) game_step("fire held");
		set_buttons(5'b00000);
		repeat (Y_MAX + 1) game_step("shell flight");
		apb_read(ADDR_STATUS, rd, 1'b0);
		compare("shell retired", 32'd0, 32'(rd[STATUS_SHELL]));

		// invalid slot on the tank cell is ignored, a valid one kills
		place_enemy(1, m.x, m.y, 1'b0);
		check_state("invalid enemy");
		place_enemy(2, m.x, m.y, 1'b1);
		check_state("hit");
		apb_read(ADDR_STATUS, rd, 1'b0);
		compare("dead", 32'd0, 32'(rd[STATUS_ALIVE]));
		set_buttons(5'b10001);
		repeat (3) game_step("dead tank");

		// respawn restores the tank and drops a flying shell
		place_enemy(2, m.x, m.y, 1'b0);
		respawn_tank("respawn");
		game_step("fire after respawn");
		respawn_tank("respawn with shell");

		// free-running tick moves the tank without steps
		set_buttons(5'b00001);
		apb_write(ADDR_TICKDIV, 32'd9, 1'b0);
		polls = 0;
		apb_read(ADDR_STATUS, rd, 1'b0);
		while ((rd[FLD_Y_LSB +: 5] <= SPAWN_Y) && (polls < POLL_TIMEOUT))
		begin
			apb_read(ADDR_STATUS, rd, 1'b0);
			polls++;
		end
		if (rd[FLD_Y_LSB +: 5] <= SPAWN_Y)
		begin
			$display("ERROR: tank never moved with the free-running tick");
			errors++;
		end
		else
			compare("free tick move", 32'(SPAWN_Y + 5'd1), 32'(rd[FLD_Y_LSB +: 5]));
		apb_write(ADDR_TICKDIV, 32'd0, 1'b0);
		set_buttons(5'b00000);

		$display("errors: %0d of %0d checks", errors, checks);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/tank_game_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module tank_game_asserts import tank_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n,
	input  wire            tick,
	input  wire tick_div_t tick_div,
	input  wire coord_t    pos_x,
	input  wire coord_t    pos_y,
	input  wire            fire,
	input  wire            shell_active
);

	// free-running ticks are at least two cycles apart
	tick_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		(tick && (tick_div != '0)) |=> !tick)
		else $error("tick high on two cycles in a row with a nonzero divider");

	// tank stays on the playfield
	x_in_field: assert property (@(posedge clk) disable iff (!rst_n) pos_x <= X_MAX)
		else $error("tank column beyond the right edge");
	y_in_field: assert property (@(posedge clk) disable iff (!rst_n) pos_y <= Y_MAX)
		else $error("tank row beyond the top edge");

	// only one shell in flight
	single_shell: assert property (@(posedge clk) disable iff (!rst_n)
		!(fire && shell_active))
		else $error("fire pulse while the shell is still active");

endmodule

bind tank_game tank_game_asserts u_asserts (
	.clk          (clk),
	.rst_n        (rst_n),
	.tick         (tick),
	.tick_div     (tick_div),
	.pos_x        (pos_x),
	.pos_y        (pos_y),
	.fire         (fire),
	.shell_active (shell_active)
);

`default_nettype wire

/* logic/tank_game.sv */
`timescale 1ns/100ps
`default_nettype none

module tank_game
	import tank_pkg::*;
	import tank_regs_pkg::*;
(
	input  wire              clk,
	input  wire              rst_n,
	// host port
	input  wire              psel,
	input  wire              penable,
	input  wire              pwrite,
	input  wire [APB_AW-1:0] paddr,
	input  wire [APB_DW-1:0] pwdata,
	output wire [APB_DW-1:0] prdata,
	output wire              pready,
	output wire              pslverr
);

	// ------------------------------
	// control from the registers
	// ------------------------------
	wire                       enable;
	wire                       respawn;
	wire                       step;
	wire                       btn_up;
	wire                       btn_down;
	wire                       btn_left;
	wire                       btn_right;
	wire                       btn_fire;
	wire tick_div_t            tick_div;
	wire [N_ENEMY-1:0]         enemy_valid;
	wire coord_t [N_ENEMY-1:0] enemy_x;
	wire coord_t [N_ENEMY-1:0] enemy_y;

	// game tick enable
	wire                       tick;

	// ------------------------------
	// tank and shell state
	// ------------------------------
	wire coord_t               pos_x;
	wire coord_t               pos_y;
	wire dir_t                 dir;
	wire                       alive;
	wire                       fire;
	wire                       shell_active;
	wire coord_t               shell_x;
	wire coord_t               shell_y;

	// port names match the wires above one to one
	tank_apb_regs u_regs (.*);

	tick_gen u_tick (.*);

	player_tank u_tank (.*);

	shell_unit u_shell (.*);

endmodule

`default_nettype wire

/* logic/tank_apb_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module tank_apb_regs
	import tank_pkg::*;
	import tank_regs_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst_n,
	// apb slave
	input  wire                       psel,
	input  wire                       penable,
	input  wire                       pwrite,
	input  wire [APB_AW-1:0]          paddr,
	input  wire [APB_DW-1:0]          pwdata,
	output logic [APB_DW-1:0]         prdata,
	output logic                      pready,
	output logic                      pslverr,
	// register outputs
	output logic                      enable,
	output logic                      respawn,
	output logic                      step,
	output logic                      btn_up,
	output logic                      btn_down,
	output logic                      btn_left,
	output logic                      btn_right,
	output logic                      btn_fire,
	output tick_div_t                 tick_div,
	output logic [N_ENEMY-1:0]        enemy_valid,
	output coord_t [N_ENEMY-1:0]      enemy_x,
	output coord_t [N_ENEMY-1:0]      enemy_y,
	// status inputs
	input  wire coord_t               pos_x,
	input  wire coord_t               pos_y,
	input  wire dir_t                 dir,
	input  wire                       alive,
	input  wire                       shell_active,
	input  wire coord_t               shell_x,
	input  wire coord_t               shell_y
);

	localparam int CW = $bits(coord_t);

	logic               access;
	logic               read_only;
	logic               mapped;
	logic               wr_en;
	logic [N_ENEMY-1:0] enemy_sel;

	// ------------------------------
	// address decode
	// ------------------------------
	always_comb
	begin
		for (int i = 0; i < N_ENEMY; i++)
			enemy_sel[i] = (paddr == APB_AW'(ADDR_ENEMY0 + i * ENEMY_STRIDE));
	end

	assign access    = psel && penable;
	assign read_only = (paddr == ADDR_STATUS) || (paddr == ADDR_SHELL);
	assign mapped    = (paddr == ADDR_CTRL) || (paddr == ADDR_BTN) ||
		(paddr == ADDR_TICKDIV) || read_only || (|enemy_sel);
	assign wr_en     = access && pwrite && mapped && !read_only;

	// no wait states
	assign pready  = 1'b1;
	// unmapped address, or a write to a read-only register
	assign pslverr = access && (!mapped || (pwrite && read_only));

	// ------------------------------
	// writable registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			enable      <= 1'b0;
			respawn     <= 1'b0;
			step        <= 1'b0;
			btn_up      <= 1'b0;
			btn_down    <= 1'b0;
			btn_left    <= 1'b0;
			btn_right   <= 1'b0;
			btn_fire    <= 1'b0;
			tick_div    <= '0;
			enemy_valid <= '0;
			enemy_x     <= '0;
			enemy_y     <= '0;
		end
		else
		begin
			// pulses, never stored
			respawn <= 1'b0;
			step    <= 1'b0;
			if (wr_en)
			begin
				case (paddr)
					ADDR_CTRL:
					begin
						enable  <= pwdata[CTRL_ENABLE];
						respawn <= pwdata[CTRL_RESPAWN];
						step    <= pwdata[CTRL_STEP];
					end
					ADDR_BTN:
					begin
						btn_up    <= pwdata[BTN_UP];
						btn_down  <= pwdata[BTN_DOWN];
						btn_left  <= pwdata[BTN_LEFT];
						btn_right <= pwdata[BTN_RIGHT];
						btn_fire  <= pwdata[BTN_FIRE];
					end
					ADDR_TICKDIV:
						tick_div <= pwdata[TICKDIV_LSB +: $bits(tick_div_t)];
					default:
					begin
						// whichever enemy slot is addressed
						for (int i = 0; i < N_ENEMY; i++)
						begin
							if (enemy_sel[i])
							begin
								enemy_x[i]     <= pwdata[FLD_X_LSB +: CW];
								enemy_y[i]     <= pwdata[FLD_Y_LSB +: CW];
								enemy_valid[i] <= pwdata[ENEMY_VALID];
							end
						end
					end
				endcase
			end
		end
	end

	// ------------------------------
	// read data, unused bits zero
	// ------------------------------
	always_comb
	begin
		prdata = '0;
		case (paddr)
			ADDR_CTRL:
				prdata[CTRL_ENABLE] = enable;
			ADDR_BTN:
			begin
				prdata[BTN_UP]    = btn_up;
				prdata[BTN_DOWN]  = btn_down;
				prdata[BTN_LEFT]  = btn_left;
				prdata[BTN_RIGHT] = btn_right;
				prdata[BTN_FIRE]  = btn_fire;
			end
			ADDR_TICKDIV:
				prdata[TICKDIV_LSB +: $bits(tick_div_t)] = tick_div;
			ADDR_STATUS:
			begin
				prdata[FLD_X_LSB +: CW]                  = pos_x;
				prdata[FLD_Y_LSB +: CW]                  = pos_y;
				prdata[STATUS_DIR_LSB +: $bits(dir_t)]   = dir;
				prdata[STATUS_ALIVE]                     = alive;
				prdata[STATUS_SHELL]                     = shell_active;
			end
			ADDR_SHELL:
			begin
				prdata[FLD_X_LSB +: CW] = shell_x;
				prdata[FLD_Y_LSB +: CW] = shell_y;
			end
			default:
			begin
				for (int i = 0; i < N_ENEMY; i++)
				begin
					if (enemy_sel[i])
					begin
						prdata[FLD_X_LSB +: CW] = enemy_x[i];
						prdata[FLD_Y_LSB +: CW] = enemy_y[i];
						prdata[ENEMY_VALID]     = enemy_valid[i];
					end
				end
			end
		endcase
	end

endmodule

`default_nettype wire

/* logic/shell_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module shell_unit import tank_pkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         tick,
	input  wire         fire,
	input  wire coord_t pos_x,
	input  wire coord_t pos_y,
	input  wire dir_t   dir,
	input  wire         respawn,
	output logic        shell_active,
	output coord_t      shell_x,
	output coord_t      shell_y
);

	dir_t   shell_dir;
	logic   at_edge;
	coord_t step_x;
	coord_t step_y;

	// ------------------------------
	// next cell along the heading
	// ------------------------------
	always_comb
	begin
		at_edge = 1'b0;
		step_x  = shell_x;
		step_y  = shell_y;
		case (shell_dir)
			DIR_UP:
			begin
				at_edge = (shell_y == Y_MAX);
				step_y  = shell_y + 1'b1;
			end
			DIR_DOWN:
			begin
				at_edge = (shell_y == '0);
				step_y  = shell_y - 1'b1;
			end
			DIR_LEFT:
			begin
				at_edge = (shell_x == '0);
				step_x  = shell_x - 1'b1;
			end
			default:
			begin
				at_edge = (shell_x == X_MAX);
				step_x  = shell_x + 1'b1;
			end
		endcase
	end

	// ------------------------------
	// flight
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shell_active <= 1'b0;
			shell_x      <= '0;
			shell_y      <= '0;
			shell_dir    <= DIR_UP;
		end
		else if (respawn)
			shell_active <= 1'b0;
		else if (fire)
		begin
			// launch from the tank cell with the tank heading
			shell_active <= 1'b1;
			shell_x      <= pos_x;
			shell_y      <= pos_y;
			shell_dir    <= dir;
		end
		else if (tick && shell_active)
		begin
			// a step off the field retires the shell and keeps the last cell
			if (at_edge)
				shell_active <= 1'b0;
			else
			begin
				shell_x <= step_x;
				shell_y <= step_y;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/player_tank.sv */
`timescale 1ns/100ps
`default_nettype none

module player_tank import tank_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       tick,
	input  wire                       enable,
	input  wire                       respawn,
	input  wire                       btn_up,
	input  wire                       btn_down,
	input  wire                       btn_left,
	input  wire                       btn_right,
	input  wire                       btn_fire,
	input  wire [N_ENEMY-1:0]         enemy_valid,
	input  wire coord_t [N_ENEMY-1:0] enemy_x,
	input  wire coord_t [N_ENEMY-1:0] enemy_y,
	input  wire                       shell_active,
	output coord_t                    pos_x,
	output coord_t                    pos_y,
	output dir_t                      dir,
	output logic                      alive,
	output logic                      fire
);

	logic   hit;
	logic   can_act;
	dir_t   next_dir;
	coord_t next_x;
	coord_t next_y;

	// ------------------------------
	// hit check, every cycle
	// ------------------------------
	always_comb
	begin
		hit = 1'b0;
		for (int i = 0; i < N_ENEMY; i++)
		begin
			// only valid slots count
			if (enemy_valid[i] && (enemy_x[i] == pos_x) && (enemy_y[i] == pos_y))
				hit = 1'b1;
		end
	end

	// a tank hit this cycle no longer moves or fires
	assign can_act = enable && alive && !hit;

	// ------------------------------
	// button priority and edge stops
	// ------------------------------
	always_comb
	begin
		next_dir = dir;
		next_x   = pos_x;
		next_y   = pos_y;
		// first pressed button wins: up, down, left, right
		if (btn_up)
		begin
			next_dir = DIR_UP;
			if (pos_y != Y_MAX)
				next_y = pos_y + 1'b1;
		end
		else if (btn_down)
		begin
			next_dir = DIR_DOWN;
			if (pos_y != '0)
				next_y = pos_y - 1'b1;
		end
		else if (btn_left)
		begin
			next_dir = DIR_LEFT;
			if (pos_x != '0)
				next_x = pos_x - 1'b1;
		end
		else if (btn_right)
		begin
			next_dir = DIR_RIGHT;
			if (pos_x != X_MAX)
				next_x = pos_x + 1'b1;
		end
	end

	// ------------------------------
	// state registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pos_x <= SPAWN_X;
			pos_y <= SPAWN_Y;
			dir   <= DIR_UP;
			alive <= 1'b1;
			fire  <= 1'b0;
		end
		else if (respawn)
		begin
			// respawn beats a tick in the same cycle
			pos_x <= SPAWN_X;
			pos_y <= SPAWN_Y;
			dir   <= DIR_UP;
			alive <= 1'b1;
			fire  <= 1'b0;
		end
		else
		begin
			fire <= 1'b0;
			// sticky until respawn
			if (hit)
				alive <= 1'b0;
			if (tick && can_act)
			begin
				pos_x <= next_x;
				pos_y <= next_y;
				dir   <= next_dir;
				// one shell in flight at a time
				fire  <= btn_fire && !shell_active;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/tick_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tick_gen import tank_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  tick_div_t tick_div,
	input  wire       step,
	output logic      tick
);

	tick_div_t cnt;
	logic      free_tick;

	// counter expired, only counts while the divider is nonzero
	assign free_tick = (tick_div != '0) && (cnt == '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			// reload on expiry, park at zero while the divider is off
			if (tick_div == '0)
				cnt <= '0;
			else if (cnt == '0)
				cnt <= tick_div;
			else
				cnt <= cnt - 1'b1;

			// one tick every tick_div+1 cycles, a step request lands a cycle later
			tick <= free_tick | step;
		end
	end

endmodule

`default_nettype wire

/* logic/tank_regs_pkg.sv */
`default_nettype none

package tank_regs_pkg;

	// bus widths
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// ------------------------------
	// register map
	// ------------------------------
	localparam logic [APB_AW-1:0] ADDR_CTRL    = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_BTN     = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_TICKDIV = 8'h08;
	localparam logic [APB_AW-1:0] ADDR_STATUS  = 8'h0C;
	localparam logic [APB_AW-1:0] ADDR_SHELL   = 8'h10;
	localparam logic [APB_AW-1:0] ADDR_ENEMY0  = 8'h20;
	// byte step between enemy slots
	localparam int ENEMY_STRIDE = 4;

	// ctrl bits, respawn and step are pulses
	localparam int CTRL_ENABLE  = 0;
	localparam int CTRL_RESPAWN = 1;
	localparam int CTRL_STEP    = 2;

	// button bits
	localparam int BTN_UP    = 0;
	localparam int BTN_DOWN  = 1;
	localparam int BTN_LEFT  = 2;
	localparam int BTN_RIGHT = 3;
	localparam int BTN_FIRE  = 4;

	// divider sits at the bottom of TICKDIV
	localparam int TICKDIV_LSB = 0;

	// x/y layout, same in STATUS, SHELL and the enemy slots
	localparam int FLD_X_LSB = 0;
	localparam int FLD_Y_LSB = 8;

	// remaining status and slot bits
	localparam int STATUS_DIR_LSB = 16;
	localparam int STATUS_ALIVE   = 20;
	localparam int STATUS_SHELL   = 21;
	localparam int ENEMY_VALID    = 16;

endpackage

`default_nettype wire

/* logic/tank_pkg.sv */
`default_nettype none

package tank_pkg;

	// ------------------------------
	// playfield geometry, in cells
	// ------------------------------
	typedef logic [4:0] coord_t;
	localparam coord_t X_MAX = 5'd15;
	localparam coord_t Y_MAX = 5'd19;

	// heading shared by tank and shell
	typedef logic [1:0] dir_t;
	localparam dir_t DIR_UP    = 2'd0;
	localparam dir_t DIR_DOWN  = 2'd1;
	localparam dir_t DIR_LEFT  = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	// spawn cell, also where reset puts the tank
	localparam coord_t SPAWN_X = 5'd7;
	localparam coord_t SPAWN_Y = 5'd7;

	// enemy shell slots written by the host
	localparam int N_ENEMY = 4;

	// game tick divider value
	typedef logic [15:0] tick_div_t;

endpackage

`default_nettype wire
